/* project.f */
+incdir+.
core_bus_pkg.sv
wb_initiator_bridge.sv
wb_amo_memory.sv
core_bus_top.sv
tb_core_bus.sv

/* Makefile */
# Verilator simulation of the core bus subsystem.

LOG = sim.log

sim:
	verilator --binary --timing --assert -j 0 -f project.f --top-module tb_core_bus
	./obj_dir/Vtb_core_bus | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tb_core_bus_checks.svh */
// Core bus checks

	// Expected words for the pending request on each port.
	word_t d_expect;
	word_t i_expect;
	logic  d_check;
	logic  i_check;
	logic  request_seen; // Set by the first valid.
	logic  prio_active;  // Both ports were raised together.
	logic  d_served;

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		$display("FAIL at time %0t: %s expected 0x%08h, got 0x%08h",
			$time, name, expected, actual);
		end_in_failure();
	endtask

	// Free bus: bridge grant, memory wait states, ack, ready.
	task automatic check_latency(input int cycles);
		if (cycles != MEM_WAIT + 3) begin
			$display("FAIL at time %0t: dready latency expected %0d, got %0d",
				$time, MEM_WAIT + 3, cycles);
			end_in_failure();
		end
	endtask

	a_quiet_before_request: assert property (@(posedge clock) disable iff (reset)
		!request_seen |-> !(dready || iready))
		else begin
			$display("A ready pulse appeared before any request was made");
			end_in_failure();
		end

	a_drdata_model: assert property (@(posedge clock) disable iff (reset)
		(dready && d_check) |-> (drdata == d_expect))
		else report_mismatch("drdata", d_expect, drdata);

	a_idata_model: assert property (@(posedge clock) disable iff (reset)
		(iready && i_check) |-> (idata == i_expect))
		else report_mismatch("idata", i_expect, idata);

	// One returned word per cycle.
	a_ready_apart: assert property (@(posedge clock) disable iff (reset)
		!(dready && iready))
		else begin
			$display("dready and iready pulsed in the same cycle");
			end_in_failure();
		end

	a_data_first: assert property (@(posedge clock) disable iff (reset)
		(iready && prio_active) |-> d_served)
		else begin
			$display("Fetch was served before the data request it competed with");
			end_in_failure();
		end

	a_dready_needs_valid: assert property (@(posedge clock) disable iff (reset)
		dready |-> dvalid)
		else begin
			$display("dready pulsed while no data request was held");
			end_in_failure();
		end

	a_iready_needs_valid: assert property (@(posedge clock) disable iff (reset)
		iready |-> ivalid)
		else begin
			$display("iready pulsed while no fetch request was held");
			end_in_failure();
		end

/* tb_core_bus.sv */
// Core bus testbench
`timescale 1ns/1ps
`default_nettype none

module tb_core_bus
	import core_bus_pkg::*;
();

	logic      clock;
	logic      reset;
	logic      dvalid;
	data_req_t data_req;
	logic      dready;
	word_t     drdata;
	logic      ivalid;
	addr_t     iaddr;
	logic      iready;
	word_t     idata;

	localparam int READY_TIMEOUT = 40; // Cycles allowed for one ready pulse.
	localparam int N_ADDRS = 12;

	word_t  model [MEM_WORDS];   // Reference copy of the memory.
	bit     written [MEM_WORDS]; // Words with a known full value.
	addr_t  addr_list [N_ADDRS];
	integer seed;

	core_bus_top i_core_bus_top (
		.clock    (clock),
		.reset    (reset),
		.dvalid   (dvalid),
		.data_req (data_req),
		.dready   (dready),
		.drdata   (drdata),
		.ivalid   (ivalid),
		.iaddr    (iaddr),
		.iready   (iready),
		.idata    (idata)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic end_in_failure();
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	`include "tb_core_bus_checks.svh"

	function automatic int word_index(input addr_t addr);
		return int'((addr >> 2) % MEM_WORDS);
	endfunction

	// Strobed lanes take the new bytes.
	function automatic word_t merge_lanes(input word_t old_val, input word_t wdata,
			input strobe_t strobe);
		word_t mask;
		mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
		return (old_val & ~mask) | (wdata & mask);
	endfunction

	// Value left in memory by an atomic operation.
	function automatic word_t amo_expected(input amo_op_t op, input word_t mem_val,
			input word_t operand);
		int a;
		int b;
		a = mem_val;
		b = operand;
		case (op)
			AMO_SWAP: return operand;
			AMO_ADD:  return mem_val + operand;
			AMO_XOR:  return mem_val ^ operand;
			AMO_AND:  return mem_val & operand;
			AMO_OR:   return mem_val | operand;
			AMO_MIN:  return word_t'((a < b) ? a : b);
			AMO_MAX:  return word_t'((a > b) ? a : b);
			AMO_MINU: return (mem_val < operand) ? mem_val : operand;
			AMO_MAXU: return (mem_val > operand) ? mem_val : operand;
			default:  return mem_val;
		endcase
	endfunction

	task automatic wait_ready(input logic fetch, output int cycles);
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			seen = fetch ? iready : dready;
			if (!seen) begin
				cycles++;
				if (cycles > READY_TIMEOUT) begin
					$display("Timeout: no %s pulse within %0d cycles",
						fetch ? "iready" : "dready", READY_TIMEOUT);
					end_in_failure();
				end
			end
		end
	endtask

	task automatic data_transfer(input addr_t addr, input word_t wdata, input strobe_t strobe,
			input logic write, input amo_op_t amo, input logic check_word,
			input word_t expect_word);
		int cycles;
		@(negedge clock);
		request_seen = 1'b1;
		d_check = check_word;
		d_expect = expect_word;
		data_req = '{addr: addr, wdata: wdata, strobe: strobe, write: write, amo: amo};
		dvalid = 1'b1;
		wait_ready(1'b0, cycles);
		@(negedge clock);
		dvalid = 1'b0; // Dropped in the cycle after the pulse.
		check_latency(cycles);
	endtask

	task automatic write_word(input addr_t addr, input word_t wdata, input strobe_t strobe);
		int idx;
		idx = word_index(addr);
		model[idx] = merge_lanes(model[idx], wdata, strobe);
		if (strobe == 4'hF) begin
			written[idx] = 1'b1;
		end
		data_transfer(addr, wdata, strobe, 1'b1, AMO_NONE, 1'b0, '0);
	endtask

	task automatic read_word(input addr_t addr);
		data_transfer(addr, '0, '0, 1'b0, AMO_NONE, 1'b1, model[word_index(addr)]);
	endtask

	task automatic amo_word(input addr_t addr, input amo_op_t op, input word_t operand);
		int    idx;
		word_t old_val;
		idx = word_index(addr);
		old_val = model[idx];
		model[idx] = amo_expected(op, old_val, operand);
		data_transfer(addr, operand, 4'hF, 1'b1, op, 1'b1, old_val); // Old word comes back.
	endtask

	task automatic fetch_word(input addr_t addr);
		int cycles;
		@(negedge clock);
		request_seen = 1'b1;
		i_check = written[word_index(addr)];
		i_expect = model[word_index(addr)];
		iaddr = addr;
		ivalid = 1'b1;
		wait_ready(1'b1, cycles);
		@(negedge clock);
		ivalid = 1'b0;
	endtask

	// Both ports ask in the same cycle and hold until served.
	task automatic both_ports(input addr_t daddr, input addr_t faddr);
		int   cycles;
		logic d_done;
		logic i_done;
		@(negedge clock);
		d_check = 1'b1;
		d_expect = model[word_index(daddr)];
		i_check = 1'b1;
		i_expect = model[word_index(faddr)];
		prio_active = 1'b1;
		d_served = 1'b0;
		data_req = '{addr: daddr, wdata: '0, strobe: '0, write: 1'b0, amo: AMO_NONE};
		iaddr = faddr;
		dvalid = 1'b1;
		ivalid = 1'b1;
		cycles = 0;
		d_done = 1'b0;
		i_done = 1'b0;
		while (!(d_done && i_done)) begin
			@(negedge clock);
			// A served port drops valid one cycle after its pulse.
			if (d_done) begin
				dvalid = 1'b0;
			end
			if (i_done) begin
				ivalid = 1'b0;
			end
			if (dready) begin
				d_done = 1'b1;
				d_served = 1'b1;
			end
			if (iready) begin
				i_done = 1'b1;
			end
			cycles++;
			if (cycles > 2 * READY_TIMEOUT) begin
				$display("Timeout: both ports not served within %0d cycles",
					2 * READY_TIMEOUT);
				end_in_failure();
			end
		end
		@(negedge clock); // Last pulse is sampled before valid and the flag drop.
		dvalid = 1'b0;
		ivalid = 1'b0;
		prio_active = 1'b0;
	endtask

	initial begin
		strobe_t strobe;
		int      pick;
		amo_op_t op;
		seed = 23;
		reset = 1'b1;
		dvalid = 1'b0;
		data_req = '0;
		ivalid = 1'b0;
		iaddr = '0;
		request_seen = 1'b0;
		d_check = 1'b0;
		i_check = 1'b0;
		d_expect = '0;
		i_expect = '0;
		prio_active = 1'b0;
		d_served = 1'b0;
		for (int k = 0; k < MEM_WORDS; k++) begin
			model[k] = '0;
			written[k] = 1'b0;
		end
		repeat (16) @(negedge clock);
		reset = 1'b0;
		repeat (8) @(negedge clock); // Idle bus, ready outputs must stay low.

		for (int k = 0; k < N_ADDRS; k++) begin
			addr_list[k] = addr_t'($random(seed)) & ~addr_t'(3);
			write_word(addr_list[k], $random(seed), 4'hF);
		end
		for (int k = 0; k < N_ADDRS; k++) begin
			read_word(addr_list[k]);
		end

		// Partial strobes on words that are already known.
		for (int k = 0; k < 8; k++) begin
			strobe = strobe_t'($random(seed));
			if (strobe == 4'hF || strobe == 4'h0) begin
				strobe = 4'b0101;
			end
			write_word(addr_list[k], $random(seed), strobe);
			read_word(addr_list[k]);
		end

		for (int k = 0; k < N_ADDRS; k++) begin
			fetch_word(addr_list[k]);
		end
		fetch_word(addr_t'($random(seed)) & ~addr_t'(3));

		for (int k = 0; k < 4; k++) begin
			both_ports(addr_list[{$random(seed)} % N_ADDRS],
				addr_list[{$random(seed)} % N_ADDRS]);
		end

		op = AMO_SWAP;
		for (int n = 0; n < 9; n++) begin
			for (int r = 0; r < 2; r++) begin
				pick = {$random(seed)} % N_ADDRS;
				write_word(addr_list[pick], $random(seed), 4'hF);
				amo_word(addr_list[pick], op, $random(seed));
				read_word(addr_list[pick]);
			end
			op = op.next();
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* core_bus_top.sv */
// Core memory subsystem top
`timescale 1ns/1ps
`default_nettype none

module core_bus_top
	import core_bus_pkg::*;
(
	input  wire       clock,
	input  wire       reset,

	// Core data port.
	input  wire       dvalid,
	input  data_req_t data_req,
	output logic      dready,
	output word_t     drdata,

	// Core fetch port.
	input  wire       ivalid,
	input  addr_t     iaddr,
	output logic      iready,
	output word_t     idata
);

	wb_req_t bus_req; // Bridge to memory.
	wb_rsp_t bus_rsp; // Memory to bridge.

	wb_initiator_bridge i_bridge (
		.clock    (clock),
		.reset    (reset),
		.dvalid   (dvalid),
		.data_req (data_req),
		.dready   (dready),
		.drdata   (drdata),
		.ivalid   (ivalid),
		.iaddr    (iaddr),
		.iready   (iready),
		.idata    (idata),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp)
	);

	// Single target on the bus.
	wb_amo_memory i_memory (
		.clock   (clock),
		.reset   (reset),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

endmodule

`default_nettype wire

/* wb_amo_memory.sv */
// Wishbone RAM with atomics
`timescale 1ns/1ps
`default_nettype none

module wb_amo_memory
	import core_bus_pkg::*;
(
	input  wire     clock,
	input  wire     reset,
	input  wb_req_t bus_req,
	output wb_rsp_t bus_rsp
);

	word_t       mem [MEM_WORDS];

	wait_count_t wait_count;
	logic        ack_q;
	word_t       rdata_q;

	logic        selected;
	logic        last_wait;
	logic        access;
	logic        is_amo;
	mem_index_t  index;
	word_t       old_word;
	word_t       merged_word;
	word_t       amo_word;
	word_t       store_word;

	// Result of an atomic read-modify-write.
	function automatic word_t amo_apply(amo_op_t op, word_t old_val, word_t operand);
		word_t result;
		case (op)
			AMO_SWAP: result = operand;
			AMO_ADD:  result = old_val + operand;
			AMO_XOR:  result = old_val ^ operand;
			AMO_AND:  result = old_val & operand;
			AMO_OR:   result = old_val | operand;
			AMO_MIN:  result = ($signed(old_val) < $signed(operand)) ? old_val : operand;
			AMO_MAX:  result = ($signed(old_val) > $signed(operand)) ? old_val : operand;
			AMO_MINU: result = (old_val < operand) ? old_val : operand;
			AMO_MAXU: result = (old_val > operand) ? old_val : operand;
			default:  result = old_val;
		endcase
		return result;
	endfunction

	assign selected  = bus_req.cyc && bus_req.stb;
	assign last_wait = (wait_count == wait_count_t'(MEM_ACK_COUNT));
	assign access    = selected && !ack_q && last_wait; // Edge that performs the transfer.
	assign is_amo    = bus_req.tgc != AMO_NONE;

	// Word select wraps modulo the depth.
	assign index    = bus_req.adr[2 +: MEM_IDX_W];
	assign old_word = mem[index];

	always_comb begin
		merged_word = old_word;
		for (int lane = 0; lane < $bits(strobe_t); lane++) begin
			if (bus_req.sel[lane]) begin
				merged_word[8*lane +: 8] = bus_req.dat_w[8*lane +: 8];
			end
		end
	end

	assign amo_word   = amo_apply(bus_req.tgc, old_word, bus_req.dat_w);
	assign store_word = is_amo ? amo_word : merged_word;

	// Wait states, then a single-cycle ack.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wait_count <= '0;
			ack_q      <= 1'b0;
		end else if (ack_q) begin
			ack_q      <= 1'b0;  // Initiator drops stb on this edge.
			wait_count <= '0;
		end else if (selected) begin
			if (last_wait) begin
				ack_q      <= 1'b1;
				wait_count <= '0;
			end else begin
				wait_count <= wait_count + 1'b1;
			end
		end else begin
			wait_count <= '0;
		end
	end

	// Reads return the old word, AMOs included.
	always_ff @(posedge clock) begin
		if (access) begin
			rdata_q <= old_word;
			if (bus_req.we) begin
				mem[index] <= store_word;
			end
		end
	end

	assign bus_rsp = '{
		ack:   ack_q,
		dat_r: rdata_q
	};

	// Ack belongs to the cycle that is still open.
	a_ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		ack_q |-> selected)
		else $error("ack outside an active cycle");

	a_amo_full_word: assert property (@(posedge clock) disable iff (reset)
		(selected && bus_req.we && is_amo) |-> (bus_req.sel == '1))
		else $error("AMO cycle without all byte strobes");

endmodule

`default_nettype wire

/* wb_initiator_bridge.sv */
// Fetch and data Wishbone bridge
`timescale 1ns/1ps
`default_nettype none

module wb_initiator_bridge
	import core_bus_pkg::*;
(
	input  wire       clock,
	input  wire       reset,

	// Core data port.
	input  wire       dvalid,
	input  data_req_t data_req,
	output logic      dready,
	output word_t     drdata,

	// Core fetch port.
	input  wire       ivalid,
	input  addr_t     iaddr,
	output logic      iready,
	output word_t     idata,

	// Wishbone initiator.
	output wb_req_t   bus_req,
	input  wb_rsp_t   bus_rsp
);

	bridge_state_t state;

	logic    cyc_q;
	logic    stb_q;
	logic    dready_q;
	logic    iready_q;

	// Request payload held for the whole cycle.
	logic    we_q;
	addr_t   adr_q;
	word_t   dat_w_q;
	strobe_t sel_q;
	amo_op_t tgc_q;
	word_t   rdata_q; // Shared by both ports.

	logic    take_data;
	logic    take_fetch;
	logic    bus_done;

	// Data wins when both ports ask in the same cycle.
	assign take_data  = (state == BR_IDLE) && dvalid;
	assign take_fetch = (state == BR_IDLE) && !dvalid && ivalid;
	assign bus_done   = cyc_q && stb_q && bus_rsp.ack;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state    <= BR_IDLE;
			cyc_q    <= 1'b0;
			stb_q    <= 1'b0;
			dready_q <= 1'b0;
			iready_q <= 1'b0;
		end else begin
			dready_q <= 1'b0; // Ready is a single-cycle pulse.
			iready_q <= 1'b0;
			case (state)
				BR_IDLE: begin
					if (take_data) begin
						state <= BR_DATA;
						cyc_q <= 1'b1;
						stb_q <= 1'b1;
					end else if (take_fetch) begin
						state <= BR_FETCH;
						cyc_q <= 1'b1;
						stb_q <= 1'b1;
					end
				end
				BR_DATA: begin
					if (bus_done) begin
						state    <= BR_TURN;
						cyc_q    <= 1'b0;
						stb_q    <= 1'b0;
						dready_q <= 1'b1;
					end
				end
				BR_FETCH: begin
					if (bus_done) begin
						state    <= BR_TURN;
						cyc_q    <= 1'b0;
						stb_q    <= 1'b0;
						iready_q <= 1'b1;
					end
				end
				BR_TURN: begin
					// Lets the requester drop valid before the next arbitration.
					state <= BR_IDLE;
				end
				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take_data) begin
			we_q    <= data_req.write;
			adr_q   <= data_req.addr;
			dat_w_q <= data_req.wdata;
			sel_q   <= data_req.strobe;
			tgc_q   <= data_req.amo;
		end else if (take_fetch) begin
			we_q    <= 1'b0;   // Fetch is always a read.
			adr_q   <= iaddr;
			dat_w_q <= '0;
			sel_q   <= '0;
			tgc_q   <= AMO_NONE;
		end
		if (bus_done) begin
			rdata_q <= bus_rsp.dat_r;
		end
	end

	assign bus_req = '{
		cyc:   cyc_q,
		stb:   stb_q,
		we:    we_q,
		adr:   adr_q,
		dat_w: dat_w_q,
		sel:   sel_q,
		tgc:   tgc_q
	};

	assign dready = dready_q;
	assign iready = iready_q;
	assign drdata = rdata_q;
	assign idata  = rdata_q;

	// Only one port can own the returned word.
	a_single_ready: assert property (@(posedge clock) disable iff (reset)
		!(dready && iready))
		else $error("dready and iready high together");

	a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		bus_req.stb |-> bus_req.cyc)
		else $error("stb high without cyc");

	// Request holds until the target acknowledges it.
	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		(bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req))
		else $error("bus request changed before ack");

endmodule

`default_nettype wire

/* core_bus_pkg.sv */
// Core bus shared definitions
`default_nettype none

package core_bus_pkg;

	// Memory geometry and timing.
	localparam int MEM_WORDS = 256;
	localparam int MEM_WAIT = 2;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS); // Word index width.
	localparam int MEM_ACK_COUNT = MEM_WAIT + 1;  // Cycles from first select to ack.

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;  // Byte address.
	typedef logic [3:0] strobe_t; // One bit per byte lane.
	typedef logic [MEM_IDX_W-1:0] mem_index_t;
	typedef logic [$clog2(MEM_ACK_COUNT + 1)-1:0] wait_count_t;

	// Atomic operation carried on the cycle tag.
	typedef enum logic [3:0] {
		AMO_NONE = 4'd0,
		AMO_SWAP = 4'd1,
		AMO_ADD  = 4'd2,
		AMO_XOR  = 4'd3,
		AMO_AND  = 4'd4,
		AMO_OR   = 4'd5,
		AMO_MIN  = 4'd6,
		AMO_MAX  = 4'd7,
		AMO_MINU = 4'd8,
		AMO_MAXU = 4'd9
	} amo_op_t;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_DATA,  // Data cycle on the bus.
		BR_FETCH, // Instruction fetch on the bus.
		BR_TURN   // One idle cycle after each transfer.
	} bridge_state_t;

	// Request from the core data port.
	typedef struct packed {
		addr_t   addr;
		word_t   wdata;
		strobe_t strobe;
		logic    write;
		amo_op_t amo;
	} data_req_t;

	// Classic Wishbone initiator outputs.
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		addr_t   adr;
		word_t   dat_w;
		strobe_t sel;
		amo_op_t tgc;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire
